// File: logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

   ////////////////////////////////////////
   // Datapath widths.
   ////////////////////////////////////////
   localparam int CANT_BITS_REGISTROS   = 32;
   localparam int CANT_REGISTROS        = 32;
   localparam int CANT_BITS_REG_IDX     = 5;
   localparam int CANT_BITS_ADDR        = 11;
   localparam int CANT_BITS_ALU_CONTROL = 4;

   // Opcode field in bits 31:26.
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_ADDI  = 6'h08;
   localparam logic [5:0] OP_SLTI  = 6'h0a;
   localparam logic [5:0] OP_ANDI  = 6'h0c;
   localparam logic [5:0] OP_ORI   = 6'h0d;
   localparam logic [5:0] OP_XORI  = 6'h0e;
   localparam logic [5:0] OP_LUI   = 6'h0f;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;

   // Funct field in bits 5:0 of an R-type word.
   localparam logic [5:0] FN_SLLV = 6'h04;
   localparam logic [5:0] FN_SRLV = 6'h06;
   localparam logic [5:0] FN_SRAV = 6'h07;
   localparam logic [5:0] FN_JALR = 6'h09;
   localparam logic [5:0] FN_ADD  = 6'h20;
   localparam logic [5:0] FN_SUB  = 6'h22;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26;
   localparam logic [5:0] FN_NOR  = 6'h27;
   localparam logic [5:0] FN_SLT  = 6'h2a;

   // ALU operation codes. Link keeps code 14.
   typedef enum logic [CANT_BITS_ALU_CONTROL-1:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_NOR  = 4'd5,
      ALU_SLT  = 4'd6,
      ALU_SLL  = 4'd7,
      ALU_SRL  = 4'd8,
      ALU_SRA  = 4'd9,
      ALU_LUI  = 4'd10,
      ALU_LINK = 4'd14
   } alu_ctrl_e;

endpackage

`default_nettype wire

// File: logic/id_ex_if.sv
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;

   // Data fields.
   logic [mips_pkg::CANT_BITS_ADDR-1:0]      adder_pc;
   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] data_a;
   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] data_b;
   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] imm_ext;
   logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   reg_rt;
   logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   reg_rd;

   // Control fields.
   logic                reg_dst;
   logic                reg_write;
   logic                alu_src;
   logic                mem_read;
   logic                mem_write;
   logic                mem_to_reg;
   mips_pkg::alu_ctrl_e alu_ctrl;

   modport fuente (
      output adder_pc, data_a, data_b, imm_ext, reg_rt, reg_rd,
      output reg_dst, reg_write, alu_src, mem_read, mem_write, mem_to_reg, alu_ctrl
   );

   modport destino (
      input adder_pc, data_a, data_b, imm_ext, reg_rt, reg_rd,
      input reg_dst, reg_write, alu_src, mem_read, mem_write, mem_to_reg, alu_ctrl
   );

endinterface

`default_nettype wire

// File: logic/ctrl_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder (
   input  wire logic [5:0]          i_opcode,
   input  wire logic [5:0]          i_funct,
   output logic                     o_reg_dst,
   output logic                     o_reg_write,
   output logic                     o_alu_src,
   output logic                     o_mem_read,
   output logic                     o_mem_write,
   output logic                     o_mem_to_reg,
   output logic                     o_zero_ext,
   output mips_pkg::alu_ctrl_e      o_alu_ctrl
);

   always_comb begin
      // Unknown codes fall through as a bubble.
      o_reg_dst    = 1'b0;
      o_reg_write  = 1'b0;
      o_alu_src    = 1'b0;
      o_mem_read   = 1'b0;
      o_mem_write  = 1'b0;
      o_mem_to_reg = 1'b0;
      o_zero_ext   = 1'b0;
      o_alu_ctrl   = mips_pkg::ALU_ADD;

      case (i_opcode)
         mips_pkg::OP_RTYPE: begin
            o_reg_dst   = 1'b1;
            o_reg_write = 1'b1;
            case (i_funct)
               mips_pkg::FN_ADD:  o_alu_ctrl = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUB:  o_alu_ctrl = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  o_alu_ctrl = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   o_alu_ctrl = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  o_alu_ctrl = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  o_alu_ctrl = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  o_alu_ctrl = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLLV: o_alu_ctrl = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRLV: o_alu_ctrl = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRAV: o_alu_ctrl = mips_pkg::ALU_SRA;
               mips_pkg::FN_JALR: o_alu_ctrl = mips_pkg::ALU_LINK;
               default: begin
                  o_reg_dst   = 1'b0;
                  o_reg_write = 1'b0;
               end
            endcase
         end
         mips_pkg::OP_LW: begin
            o_reg_write  = 1'b1;
            o_alu_src    = 1'b1;
            o_mem_read   = 1'b1;
            o_mem_to_reg = 1'b1;
         end
         mips_pkg::OP_SW: begin
            o_alu_src   = 1'b1;
            o_mem_write = 1'b1;
         end
         default: begin
            // Remaining I-type arithmetic writes rt.
            o_reg_write = 1'b1;
            o_alu_src   = 1'b1;
            case (i_opcode)
               mips_pkg::OP_ADDI: o_alu_ctrl = mips_pkg::ALU_ADD;
               mips_pkg::OP_SLTI: o_alu_ctrl = mips_pkg::ALU_SLT;
               mips_pkg::OP_ANDI: o_alu_ctrl = mips_pkg::ALU_AND;
               mips_pkg::OP_ORI:  o_alu_ctrl = mips_pkg::ALU_OR;
               mips_pkg::OP_XORI: o_alu_ctrl = mips_pkg::ALU_XOR;
               mips_pkg::OP_LUI:  o_alu_ctrl = mips_pkg::ALU_LUI;
               default: begin
                  o_reg_write = 1'b0;
                  o_alu_src   = 1'b0;
               end
            endcase
            // Logical immediates and lui take the zero extension.
            o_zero_ext = (i_opcode == mips_pkg::OP_ANDI) || (i_opcode == mips_pkg::OP_ORI) ||
                         (i_opcode == mips_pkg::OP_XORI) || (i_opcode == mips_pkg::OP_LUI);
         end
      endcase
   end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  wire logic                                     i_clock,
   input  wire logic                                     i_soft_reset,
   input  wire logic                                     i_write,
   input  wire logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   i_reg_w,
   input  wire logic [mips_pkg::CANT_BITS_REGISTROS-1:0] i_data_w,
   input  wire logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   i_reg_a,
   input  wire logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   i_reg_b,
   output logic      [mips_pkg::CANT_BITS_REGISTROS-1:0] o_data_a,
   output logic      [mips_pkg::CANT_BITS_REGISTROS-1:0] o_data_b
);

   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] regs [mips_pkg::CANT_REGISTROS];

   // Write on the falling edge so decode sees it before the next rising edge.
   always_ff @(negedge i_clock) begin
      if (!i_soft_reset) begin
         for (int i = 0; i < mips_pkg::CANT_REGISTROS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_write && (i_reg_w != '0)) begin
         regs[i_reg_w] <= i_data_w;
      end
   end

   assign o_data_a = (i_reg_a == '0) ? '0 : regs[i_reg_a];
   assign o_data_b = (i_reg_b == '0) ? '0 : regs[i_reg_b];

   // $zero stays zero across any write-back sequence.
   a_zero_reg: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      regs[0] == '0);

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  mips_pkg::alu_ctrl_e                           i_alu_ctrl,
   input  wire logic [mips_pkg::CANT_BITS_REGISTROS-1:0] i_dato_a,
   input  wire logic [mips_pkg::CANT_BITS_REGISTROS-1:0] i_dato_b,
   output logic      [mips_pkg::CANT_BITS_REGISTROS-1:0] o_resultado
);

   logic [4:0] shamt;

   // Variable shifts take the amount from rs.
   assign shamt = i_dato_a[4:0];

   always_comb begin
      case (i_alu_ctrl)
         mips_pkg::ALU_ADD:  o_resultado = i_dato_a + i_dato_b;
         mips_pkg::ALU_SUB:  o_resultado = i_dato_a - i_dato_b;
         mips_pkg::ALU_AND:  o_resultado = i_dato_a & i_dato_b;
         mips_pkg::ALU_OR:   o_resultado = i_dato_a | i_dato_b;
         mips_pkg::ALU_XOR:  o_resultado = i_dato_a ^ i_dato_b;
         mips_pkg::ALU_NOR:  o_resultado = ~(i_dato_a | i_dato_b);
         mips_pkg::ALU_SLT: begin
            o_resultado = {31'b0, ($signed(i_dato_a) < $signed(i_dato_b))};
         end
         mips_pkg::ALU_SLL:  o_resultado = i_dato_b << shamt;
         mips_pkg::ALU_SRL:  o_resultado = i_dato_b >> shamt;
         mips_pkg::ALU_SRA:  o_resultado = $unsigned($signed(i_dato_b) >>> shamt);
         mips_pkg::ALU_LUI:  o_resultado = {i_dato_b[15:0], 16'h0000};
         // Link carries the return address through untouched.
         mips_pkg::ALU_LINK: o_resultado = i_dato_a;
         default:            o_resultado = i_dato_a + i_dato_b;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/etapa_decodificacion.sv
`timescale 1ns/1ps
`default_nettype none

module etapa_decodificacion (
   input  wire logic                                     i_clock,
   input  wire logic                                     i_soft_reset,
   input  wire logic                                     i_enable_pipeline,
   input  wire logic [mips_pkg::CANT_BITS_REGISTROS-1:0] i_instruction,
   input  wire logic [mips_pkg::CANT_BITS_ADDR-1:0]      i_adder_pc,
   input  wire logic                                     i_wb_reg_write,
   input  wire logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   i_wb_reg,
   input  wire logic [mips_pkg::CANT_BITS_REGISTROS-1:0] i_wb_data,
   id_ex_if.fuente                                       o_id_ex
);

   ////////////////////////////////////////
   // Instruction fields.
   ////////////////////////////////////////
   logic [5:0]                               opcode;
   logic [5:0]                               funct;
   logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   reg_rs;
   logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   reg_rt;
   logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   reg_rd;
   logic [15:0]                              inmediato;
   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] imm_ext;
   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] data_a;
   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] data_b;

   logic                reg_dst;
   logic                reg_write;
   logic                alu_src;
   logic                mem_read;
   logic                mem_write;
   logic                mem_to_reg;
   logic                zero_ext;
   mips_pkg::alu_ctrl_e alu_ctrl;

   assign opcode    = i_instruction[31:26];
   assign reg_rs    = i_instruction[25:21];
   assign reg_rt    = i_instruction[20:16];
   assign reg_rd    = i_instruction[15:11];
   assign funct     = i_instruction[5:0];
   assign inmediato = i_instruction[15:0];

   assign imm_ext = zero_ext ? {16'h0000, inmediato} : {{16{inmediato[15]}}, inmediato};

   ctrl_decoder u_ctrl_decoder (
      .i_opcode     (opcode),
      .i_funct      (funct),
      .o_reg_dst    (reg_dst),
      .o_reg_write  (reg_write),
      .o_alu_src    (alu_src),
      .o_mem_read   (mem_read),
      .o_mem_write  (mem_write),
      .o_mem_to_reg (mem_to_reg),
      .o_zero_ext   (zero_ext),
      .o_alu_ctrl   (alu_ctrl)
   );

   register_file u_register_file (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_write      (i_wb_reg_write),
      .i_reg_w      (i_wb_reg),
      .i_data_w     (i_wb_data),
      .i_reg_a      (reg_rs),
      .i_reg_b      (reg_rt),
      .o_data_a     (data_a),
      .o_data_b     (data_b)
   );

   ////////////////////////////////////////
   // ID/EX boundary, rising edge.
   ////////////////////////////////////////
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_id_ex.adder_pc   <= '0;
         o_id_ex.data_a     <= '0;
         o_id_ex.data_b     <= '0;
         o_id_ex.imm_ext    <= '0;
         o_id_ex.reg_rt     <= '0;
         o_id_ex.reg_rd     <= '0;
         o_id_ex.reg_dst    <= 1'b0;
         o_id_ex.reg_write  <= 1'b0;
         o_id_ex.alu_src    <= 1'b0;
         o_id_ex.mem_read   <= 1'b0;
         o_id_ex.mem_write  <= 1'b0;
         o_id_ex.mem_to_reg <= 1'b0;
         o_id_ex.alu_ctrl   <= mips_pkg::ALU_ADD;
      end else if (i_enable_pipeline) begin
         o_id_ex.adder_pc   <= i_adder_pc;
         o_id_ex.data_a     <= data_a;
         o_id_ex.data_b     <= data_b;
         o_id_ex.imm_ext    <= imm_ext;
         o_id_ex.reg_rt     <= reg_rt;
         o_id_ex.reg_rd     <= reg_rd;
         o_id_ex.reg_dst    <= reg_dst;
         o_id_ex.reg_write  <= reg_write;
         o_id_ex.alu_src    <= alu_src;
         o_id_ex.mem_read   <= mem_read;
         o_id_ex.mem_write  <= mem_write;
         o_id_ex.mem_to_reg <= mem_to_reg;
         o_id_ex.alu_ctrl   <= alu_ctrl;
      end
   end

endmodule

`default_nettype wire

// File: logic/etapa_ejecucion.sv
`timescale 1ns/1ps
`default_nettype none

module etapa_ejecucion (
   input  wire logic                                     i_clock,
   input  wire logic                                     i_soft_reset,
   input  wire logic                                     i_enable_pipeline,
   id_ex_if.destino                                      i_id_ex,
   output logic                                          o_reg_write,
   output logic                                          o_mem_read,
   output logic                                          o_mem_write,
   output logic                                          o_mem_to_reg,
   output logic      [mips_pkg::CANT_BITS_REGISTROS-1:0] o_result,
   output logic      [mips_pkg::CANT_BITS_REGISTROS-1:0] o_data_write_to_mem,
   output logic      [mips_pkg::CANT_BITS_REG_IDX-1:0]   o_registro_destino
);

   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] primer_operando;
   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] segundo_operando;
   logic [mips_pkg::CANT_BITS_REGISTROS-1:0] resultado_alu;
   logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   registro_destino;

   ////////////////////////////////////////
   // Operand and destination selection.
   ////////////////////////////////////////
   assign primer_operando = (i_id_ex.alu_ctrl == mips_pkg::ALU_LINK) ?
      {{(mips_pkg::CANT_BITS_REGISTROS - mips_pkg::CANT_BITS_ADDR){1'b0}}, i_id_ex.adder_pc} :
      i_id_ex.data_a;

   assign segundo_operando = i_id_ex.alu_src ? i_id_ex.imm_ext : i_id_ex.data_b;
   assign registro_destino = i_id_ex.reg_dst ? i_id_ex.reg_rd : i_id_ex.reg_rt;

   alu u_alu (
      .i_alu_ctrl  (i_id_ex.alu_ctrl),
      .i_dato_a    (primer_operando),
      .i_dato_b    (segundo_operando),
      .o_resultado (resultado_alu)
   );

   // EX/MEM boundary sits on the falling edge.
   always_ff @(negedge i_clock) begin
      if (!i_soft_reset) begin
         o_reg_write         <= 1'b0;
         o_mem_read          <= 1'b0;
         o_mem_write         <= 1'b0;
         o_mem_to_reg        <= 1'b0;
         o_result            <= '0;
         o_data_write_to_mem <= '0;
         o_registro_destino  <= '0;
      end else if (i_enable_pipeline) begin
         o_reg_write         <= i_id_ex.reg_write;
         o_mem_read          <= i_id_ex.mem_read;
         o_mem_write         <= i_id_ex.mem_write;
         o_mem_to_reg        <= i_id_ex.mem_to_reg;
         o_result            <= resultado_alu;
         o_data_write_to_mem <= i_id_ex.data_b;
         o_registro_destino  <= registro_destino;
      end
   end

   ////////////////////////////////////////
   // Checks.
   ////////////////////////////////////////
   // A held reset leaves a bubble entering EX.
   a_reset_bubble: assert property (@(negedge i_clock)
      (!i_soft_reset && !$past(i_soft_reset)) |->
      !(i_id_ex.reg_write || i_id_ex.mem_read || i_id_ex.mem_write || i_id_ex.mem_to_reg));

   // The decoder never issues a load and a store together.
   a_mem_exclusive: assert property (@(negedge i_clock) !(o_mem_read && o_mem_write));

endmodule

`default_nettype wire

// File: logic/top_id_ex.sv
`timescale 1ns/1ps
`default_nettype none

module top_id_ex (
   input  wire logic                                     i_clock,
   input  wire logic                                     i_soft_reset,
   input  wire logic                                     i_enable_pipeline,
   input  wire logic [mips_pkg::CANT_BITS_REGISTROS-1:0] i_instruction,
   input  wire logic [mips_pkg::CANT_BITS_ADDR-1:0]      i_adder_pc,
   input  wire logic                                     i_wb_reg_write,
   input  wire logic [mips_pkg::CANT_BITS_REG_IDX-1:0]   i_wb_reg,
   input  wire logic [mips_pkg::CANT_BITS_REGISTROS-1:0] i_wb_data,
   output logic                                          o_reg_write,
   output logic                                          o_mem_read,
   output logic                                          o_mem_write,
   output logic                                          o_mem_to_reg,
   output logic      [mips_pkg::CANT_BITS_REGISTROS-1:0] o_result,
   output logic      [mips_pkg::CANT_BITS_REGISTROS-1:0] o_data_write_to_mem,
   output logic      [mips_pkg::CANT_BITS_REG_IDX-1:0]   o_registro_destino
);

   id_ex_if id_ex ();

   etapa_decodificacion u_etapa_decodificacion (
      .i_clock           (i_clock),
      .i_soft_reset      (i_soft_reset),
      .i_enable_pipeline (i_enable_pipeline),
      .i_instruction     (i_instruction),
      .i_adder_pc        (i_adder_pc),
      .i_wb_reg_write    (i_wb_reg_write),
      .i_wb_reg          (i_wb_reg),
      .i_wb_data         (i_wb_data),
      .o_id_ex           (id_ex.fuente)
   );

   etapa_ejecucion u_etapa_ejecucion (
      .i_clock             (i_clock),
      .i_soft_reset        (i_soft_reset),
      .i_enable_pipeline   (i_enable_pipeline),
      .i_id_ex             (id_ex.destino),
      .o_reg_write         (o_reg_write),
      .o_mem_read          (o_mem_read),
      .o_mem_write         (o_mem_write),
      .o_mem_to_reg        (o_mem_to_reg),
      .o_result            (o_result),
      .o_data_write_to_mem (o_data_write_to_mem),
      .o_registro_destino  (o_registro_destino)
   );

endmodule

`default_nettype wire

// File: dv/tb_top_id_ex.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top_id_ex;

   localparam int CLK_PERIOD    = 10;
   localparam int RESET_CYCLES  = 5;
   // Each write-back or instruction takes two cycles.
   localparam int NUM_WB        = 13;
   localparam int NUM_INSTR     = 22;
   localparam int STALL_CYCLES  = 8;
   localparam int RUN_CYCLES    = RESET_CYCLES + 2 * (NUM_WB + NUM_INSTR) + STALL_CYCLES;
   localparam int MARGIN_CYCLES = 100;

   // Encodings for assembling instructions.
   localparam logic [5:0] OPC_RTYPE = 6'h00;
   localparam logic [5:0] OPC_ADDI  = 6'h08;
   localparam logic [5:0] OPC_SLTI  = 6'h0a;
   localparam logic [5:0] OPC_ANDI  = 6'h0c;
   localparam logic [5:0] OPC_ORI   = 6'h0d;
   localparam logic [5:0] OPC_XORI  = 6'h0e;
   localparam logic [5:0] OPC_LUI   = 6'h0f;
   localparam logic [5:0] OPC_LW    = 6'h23;
   localparam logic [5:0] OPC_SW    = 6'h2b;
   localparam logic [5:0] FUN_SLLV  = 6'h04;
   localparam logic [5:0] FUN_SRLV  = 6'h06;
   localparam logic [5:0] FUN_SRAV  = 6'h07;
   localparam logic [5:0] FUN_JALR  = 6'h09;
   localparam logic [5:0] FUN_ADD   = 6'h20;
   localparam logic [5:0] FUN_SUB   = 6'h22;
   localparam logic [5:0] FUN_AND   = 6'h24;
   localparam logic [5:0] FUN_OR    = 6'h25;
   localparam logic [5:0] FUN_XOR   = 6'h26;
   localparam logic [5:0] FUN_NOR   = 6'h27;
   localparam logic [5:0] FUN_SLT   = 6'h2a;

   logic        clk;
   logic        soft_reset;
   logic        enable;
   logic [31:0] instruction;
   logic [10:0] adder_pc;
   logic        wb_reg_write;
   logic [4:0]  wb_reg;
   logic [31:0] wb_data;
   logic        reg_write_out;
   logic        mem_read_out;
   logic        mem_write_out;
   logic        mem_to_reg_out;
   logic [31:0] result_out;
   logic [31:0] store_out;
   logic [4:0]  dest_out;

   // Reference state.
   logic [31:0] shadow [32];
   logic [31:0] lcg_state;
   logic [31:0] exp_result;
   logic [31:0] exp_store;
   logic [4:0]  exp_dest;
   logic [3:0]  exp_ctrl;
   string       cur_test;
   int          test_errors;
   int          total_errors;
   int          total_checks;
   int          tests_run;
   int          tests_failed;

   top_id_ex dut0 (
      .i_clock             (clk),
      .i_soft_reset        (soft_reset),
      .i_enable_pipeline   (enable),
      .i_instruction       (instruction),
      .i_adder_pc          (adder_pc),
      .i_wb_reg_write      (wb_reg_write),
      .i_wb_reg            (wb_reg),
      .i_wb_data           (wb_data),
      .o_reg_write         (reg_write_out),
      .o_mem_read          (mem_read_out),
      .o_mem_write         (mem_write_out),
      .o_mem_to_reg        (mem_to_reg_out),
      .o_result            (result_out),
      .o_data_write_to_mem (store_out),
      .o_registro_destino  (dest_out)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs, rt, rd);
      return {OPC_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   ////////////////////////////////////////
   // Reference model.
   ////////////////////////////////////////
   task automatic predict(input logic [31:0] instr, input logic [10:0] pc);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] sext;
      logic [31:0] zext;
      a          = shadow[instr[25:21]];
      b          = shadow[instr[20:16]];
      sext       = {{16{instr[15]}}, instr[15:0]};
      zext       = {16'd0, instr[15:0]};
      exp_store  = b;
      exp_dest   = instr[20:16];
      exp_ctrl   = 4'b1000;
      exp_result = 32'd0;
      if (instr[31:26] == OPC_RTYPE) begin
         exp_dest = instr[15:11];
         case (instr[5:0])
            FUN_ADD:  exp_result = a + b;
            FUN_SUB:  exp_result = a - b;
            FUN_AND:  exp_result = a & b;
            FUN_OR:   exp_result = a | b;
            FUN_XOR:  exp_result = a ^ b;
            FUN_NOR:  exp_result = ~(a | b);
            FUN_SLT:  exp_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FUN_SLLV: exp_result = b << a[4:0];
            FUN_SRLV: exp_result = b >> a[4:0];
            FUN_SRAV: exp_result = $unsigned($signed(b) >>> a[4:0]);
            FUN_JALR: exp_result = {21'd0, pc};
            default:  exp_ctrl = 4'b0000;
         endcase
      end else begin
         case (instr[31:26])
            OPC_ADDI: exp_result = a + sext;
            OPC_ANDI: exp_result = a & zext;
            OPC_ORI:  exp_result = a | zext;
            OPC_XORI: exp_result = a ^ zext;
            OPC_SLTI: exp_result = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            OPC_LUI:  exp_result = {instr[15:0], 16'd0};
            OPC_LW: begin
               exp_result = a + sext;
               exp_ctrl   = 4'b1101;
            end
            OPC_SW: begin
               exp_result = a + sext;
               exp_ctrl   = 4'b0010;
            end
            default:  exp_ctrl = 4'b0000;
         endcase
      end
   endtask

   task automatic compare(input string field, input logic [31:0] expected, actual);
      total_checks++;
      if (actual !== expected) begin
         $display("FAIL %s %s expected %08h actual %08h", cur_test, field, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_outputs();
      compare("result", exp_result, result_out);
      compare("dest", {27'd0, exp_dest}, {27'd0, dest_out});
      compare("ctrl", {28'd0, exp_ctrl},
              {28'd0, reg_write_out, mem_read_out, mem_write_out, mem_to_reg_out});
      compare("store", exp_store, store_out);
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
         $display("%s passed", cur_test);
      end else begin
         tests_failed++;
         $display("%s failed with %0d errors", cur_test, test_errors);
      end
   endtask

   task automatic write_back(input logic [4:0] r, input logic [31:0] d);
      @(negedge clk);
      wb_reg_write <= 1'b1;
      wb_reg       <= r;
      wb_data      <= d;
      @(negedge clk);
      wb_reg_write <= 1'b0;
      if (r != 5'd0) begin
         shadow[r] = d;
      end
   endtask

   // Results leave EX/MEM one falling edge after the instruction is driven.
   task automatic run_instr(input logic [31:0] instr, input logic [10:0] pc);
      predict(instr, pc);
      @(negedge clk);
      instruction <= instr;
      adder_pc    <= pc;
      @(negedge clk);
      @(posedge clk);
      check_outputs();
   endtask

   ////////////////////////////////////////
   // Directed tests.
   ////////////////////////////////////////
   task automatic rtype_ops();
      logic [5:0] functs [10];
      functs = '{FUN_ADD, FUN_SUB, FUN_AND, FUN_OR, FUN_XOR,
                 FUN_NOR, FUN_SLT, FUN_SLLV, FUN_SRLV, FUN_SRAV};
      start_test("rtype");
      for (int i = 0; i < 12; i++) begin
         write_back(5'(i + 1), lcg_next());
      end
      for (int i = 0; i < 10; i++) begin
         run_instr(enc_r(functs[i], 5'(i + 1), 5'(i + 2), 5'(i + 13)), 11'd0);
      end
      end_test();
   endtask

   task automatic itype_ops();
      logic [5:0]  ops [6];
      logic [31:0] rnd;
      ops = '{OPC_ADDI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_SLTI, OPC_LUI};
      start_test("itype");
      for (int i = 0; i < 6; i++) begin
         rnd = lcg_next();
         run_instr(enc_i(ops[i], 5'(i + 1), 5'(i + 20), rnd[15:0]), 11'd0);
      end
      end_test();
   endtask

   task automatic load_store();
      logic [31:0] rnd;
      start_test("load_store");
      rnd = lcg_next();
      run_instr(enc_i(OPC_LW, 5'd4, 5'd5, rnd[15:0]), 11'd0);
      rnd = lcg_next();
      run_instr(enc_i(OPC_SW, 5'd6, 5'd7, rnd[31:16]), 11'd0);
      end_test();
   endtask

   task automatic jump_link();
      logic [31:0] rnd;
      start_test("jalr");
      rnd = lcg_next();
      run_instr(enc_r(FUN_JALR, 5'd3, 5'd0, 5'd31), rnd[10:0]);
      end_test();
   endtask

   task automatic pipeline_stall();
      start_test("stall");
      run_instr(enc_r(FUN_XOR, 5'd7, 5'd8, 5'd9), 11'd0);
      @(negedge clk);
      enable      <= 1'b0;
      instruction <= enc_i(OPC_LW, 5'd1, 5'd2, 16'h0040);
      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         check_outputs();
         @(negedge clk);
         instruction <= enc_r(FUN_SUB, 5'(i + 1), 5'(i + 5), 5'(i + 20));
      end
      enable <= 1'b1;
      run_instr(enc_i(OPC_ORI, 5'd10, 5'd11, 16'h8001), 11'd0);
      end_test();
   endtask

   task automatic zero_register();
      start_test("zero_reg");
      write_back(5'd0, 32'hdead_beef);
      run_instr(enc_r(FUN_OR, 5'd0, 5'd0, 5'd12), 11'd0);
      end_test();
   endtask

   initial begin
      soft_reset   = 1'b0;
      enable       = 1'b1;
      instruction  = 32'd0;
      adder_pc     = 11'd0;
      wb_reg_write = 1'b0;
      wb_reg       = 5'd0;
      wb_data      = 32'd0;
      lcg_state    = 32'd73;
      total_errors = 0;
      total_checks = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < 32; i++) begin
         shadow[i] = 32'd0;
      end

      repeat (RESET_CYCLES) @(posedge clk);
      start_test("reset");
      exp_result = 32'd0;
      exp_store  = 32'd0;
      exp_dest   = 5'd0;
      exp_ctrl   = 4'b0000;
      check_outputs();
      end_test();
      @(negedge clk);
      soft_reset <= 1'b1;

      rtype_ops();
      itype_ops();
      load_store();
      jump_link();
      pipeline_stall();
      zero_register();

      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, total_checks, total_errors);
      if (total_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // Watchdog.
   initial begin
      #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("Timeout: the tests did not complete in %0d cycles",
               RUN_CYCLES + MARGIN_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
logic/mips_pkg.sv
logic/id_ex_if.sv
logic/ctrl_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/etapa_decodificacion.sv
logic/etapa_ejecucion.sv
logic/top_id_ex.sv
dv/tb_top_id_ex.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ID/EX testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_top_id_ex -o tb_sim ||
   { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1
